// File: vlog.f
hw/rvPkg.sv
hw/programCounter.sv
hw/instrMemory.sv
hw/controlUnit.sv
hw/immExtend.sv
hw/regFile.sv
hw/alu.sv
hw/dataMemory.sv
hw/cpuTop.sv
tb/clockGen.sv
tb/cpuTop_properties.sv
tb/cpuTb.sv

// File: Bender.yml
package:
  name: rv32i_single_cycle

sources:
  - files:
      - hw/rvPkg.sv
      - hw/programCounter.sv
      - hw/instrMemory.sv
      - hw/controlUnit.sv
      - hw/immExtend.sv
      - hw/regFile.sv
      - hw/alu.sv
      - hw/dataMemory.sv
      - hw/cpuTop.sv
  - target: simulation
    files:
      - tb/clockGen.sv
      - tb/cpuTop_properties.sv
      - tb/cpuTb.sv

// File: tb/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import rvPkg::*; ();

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_BYTES = 256;
    localparam int RST_CYCLES = 16;
    localparam int NUM_SEGS   = 2;
    localparam int MARGIN     = 20;
    localparam logic [31:0] SEED = 32'h8628_2b1c;

    localparam logic [4:0] X0 = 5'd0;
    localparam logic [4:0] A0 = 5'd10;
    localparam logic [4:0] A1 = 5'd11;
    localparam logic [4:0] A7 = 5'd17;

    // One program word and the a0/a1/a7 expected once it retires
    typedef struct packed {
        logic       runs;
        instrWord_t instr;
        word_t      a0;
        word_t      a1;
        word_t      a7;
    } row_t;

    logic  clk;
    logic  rst;
    logic  restart;
    logic  progWe;
    word_t progAddr;
    word_t progData;
    word_t a0;
    word_t a1;
    word_t a7;

    row_t progTable[$];
    int   segFirst[NUM_SEGS];
    int   segCount[NUM_SEGS] = '{default: 0};
    int   errors = 0;
    int   cycles = 0;
    int   cycleLimit = 1000;

    clockGen #(
        .RST_CYCLES (RST_CYCLES)
    ) clkGen_i (
        .restart (restart),
        .clk     (clk),
        .rst     (rst)
    );

    cpuTop #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_BYTES (DMEM_BYTES)
    ) dut_i (
        .clk      (clk),
        .rst      (rst),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .a0       (a0),
        .a1       (a1),
        .a7       (a7)
    );

    // Small assembler for the table
    function automatic instrWord_t encR(input logic [2:0] f3, input logic [6:0] f7,
                                        input logic [4:0] rd, rs1, rs2);
        instrWord_t w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: OP_R};
        return w;
    endfunction

    function automatic instrWord_t encI(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, rs1, input logic [11:0] imm);
        instrWord_t w;
        w.i = '{imm12: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic instrWord_t encS(input logic [2:0] f3, input logic [4:0] rs2, rs1,
                                        input logic [11:0] imm);
        instrWord_t w;
        w.s = '{immHi: imm[11:5], rs2: rs2, rs1: rs1, funct3: f3, immLo: imm[4:0],
                opcode: OP_STORE};
        return w;
    endfunction

    function automatic instrWord_t encB(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                        input logic [12:0] off);
        instrWord_t w;
        w.b = '{immSign: off[12], imm10to5: off[10:5], rs2: rs2, rs1: rs1, funct3: f3,
                imm4to1: off[4:1], imm11: off[11], opcode: OP_BRANCH};
        return w;
    endfunction

    function automatic instrWord_t encU(input logic [4:0] rd, input logic [19:0] imm);
        instrWord_t w;
        w.u = '{imm20: imm, rd: rd, opcode: OP_LUI};
        return w;
    endfunction

    function automatic instrWord_t encJ(input logic [4:0] rd, input logic [20:0] off);
        instrWord_t w;
        w.j = '{immSign: off[20], imm10to1: off[10:1], imm11: off[11],
                imm19to12: off[19:12], rd: rd, opcode: OP_JAL};
        return w;
    endfunction

    function automatic void addRow(input int seg, input logic runs, input instrWord_t instr,
                                   input word_t e0, e1, e7);
        row_t row;
        row = '{runs: runs, instr: instr, a0: e0, a1: e1, a7: e7};
        if (segCount[seg] == 0) begin
            segFirst[seg] = progTable.size();
        end
        segCount[seg]++;
        progTable.push_back(row);
    endfunction

    task automatic buildTable();
        logic [11:0] r0;
        logic [11:0] r1;
        word_t       va;
        word_t       vb;
        word_t       v7;
        // a0 operand negative, a1 operand non-negative
        r0 = {1'b1, 11'($urandom)};
        r1 = {1'b0, 11'($urandom)};
        va = {{20{r0[11]}}, r0};
        vb = {{20{r1[11]}}, r1};
        // Segment 0, arithmetic and logic
        addRow(0, 1, encI(OP_IMM, 3'b000, X0, X0, 12'd7), '0, '0, '0);
        addRow(0, 1, encI(OP_IMM, 3'b000, A0, X0, r0), va, '0, '0);
        addRow(0, 1, encI(OP_IMM, 3'b000, A1, X0, r1), va, vb, '0);
        addRow(0, 1, encR(3'b000, 7'h00, A7, A0, A1), va, vb, va + vb);
        addRow(0, 1, encR(3'b000, 7'h20, A7, A0, A1), va, vb, va - vb);
        addRow(0, 1, encR(3'b111, 7'h00, A7, A0, A1), va, vb, va & vb);
        addRow(0, 1, encR(3'b110, 7'h00, A7, A0, A1), va, vb, va | vb);
        addRow(0, 1, encR(3'b100, 7'h00, A7, A0, A1), va, vb, va ^ vb);
        addRow(0, 1, encR(3'b010, 7'h00, A7, A0, A1), va, vb, 32'd1);
        addRow(0, 1, encR(3'b010, 7'h00, A7, A1, A0), va, vb, 32'd0);
        v7 = 32'h8765_4000;
        addRow(0, 1, encU(A7, 20'h87654), va, vb, v7);
        v7 = v7 << vb[4:0];
        addRow(0, 1, encR(3'b001, 7'h00, A7, A7, A1), va, vb, v7);
        v7 = va >> vb[4:0];
        addRow(0, 1, encR(3'b101, 7'h00, A7, A0, A1), va, vb, v7);
        va = ~va;
        addRow(0, 1, encI(OP_IMM, 3'b100, A0, A0, 12'hfff), va, vb, v7);
        vb = vb & 32'h0000_00ff;
        addRow(0, 1, encI(OP_IMM, 3'b111, A1, A1, 12'h0ff), va, vb, v7);
        v7 = ($signed(va) < 32'sd1) ? 32'd1 : 32'd0;
        addRow(0, 1, encI(OP_IMM, 3'b010, A7, A0, 12'd1), va, vb, v7);
        // Segment 1, memory, branches and jumps
        va = 32'h1234_5678;
        vb = 32'hffff_ff90;
        addRow(1, 1, encU(A0, 20'h12345), 32'h1234_5000, '0, '0);
        addRow(1, 1, encI(OP_IMM, 3'b000, A0, A0, 12'h678), va, '0, '0);
        addRow(1, 1, encS(3'b010, A0, X0, 12'd16), va, '0, '0);
        addRow(1, 1, encI(OP_IMM, 3'b000, A1, X0, 12'hf90), va, vb, '0);
        addRow(1, 1, encS(3'b000, A1, X0, 12'd17), va, vb, '0);
        // Byte 17 replaced, bytes 16, 18 and 19 kept
        addRow(1, 1, encI(OP_LOAD, 3'b010, A7, X0, 12'd16), va, vb, 32'h1234_9078);
        addRow(1, 1, encI(OP_LOAD, 3'b000, A7, X0, 12'd17), va, vb, 32'hffff_ff90);
        addRow(1, 1, encI(OP_LOAD, 3'b100, A7, X0, 12'd17), va, vb, 32'h0000_0090);
        addRow(1, 1, encB(3'b000, A7, A7, 13'd8), va, vb, 32'h0000_0090);
        addRow(1, 0, encI(OP_IMM, 3'b000, A0, X0, 12'd1), '0, '0, '0);
        addRow(1, 1, encB(3'b001, A1, A1, 13'd8), va, vb, 32'h0000_0090);
        // JAL at 44 links 48 and lands on 52
        addRow(1, 1, encJ(A0, 21'd8), 32'd48, vb, 32'h0000_0090);
        addRow(1, 0, encI(OP_IMM, 3'b000, A7, X0, 12'd5), '0, '0, '0);
        // JALR to 48 + 13, bit 0 cleared gives 60
        addRow(1, 1, encI(OP_JALR, 3'b000, A1, A0, 12'd13), 32'd48, 32'd56, 32'h0000_0090);
        addRow(1, 0, encI(OP_IMM, 3'b000, A7, X0, 12'd5), '0, '0, '0);
        addRow(1, 1, encI(OP_IMM, 3'b000, A7, A7, 12'h100), 32'd48, 32'd56, 32'h0000_0190);
    endtask

    // Called on a falling edge while rst is high, fills every reset cycle
    task automatic loadSegment(input int seg);
        for (int k = 0; k < RST_CYCLES; k++) begin
            progWe   = 1'b1;
            progAddr = word_t'(4 * k);
            progData = (k < segCount[seg]) ? progTable[segFirst[seg] + k].instr.raw : '0;
            @(negedge clk);
        end
        progWe = 1'b0;
    endtask

    task automatic checkReg(input int idx, input string name, input word_t expected,
                            input word_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: row %0d %s expected %h, got %h",
                     $time, idx, name, expected, actual);
            errors++;
        end
    endtask

    task automatic runSegment(input int seg);
        row_t row;
        int   idx;
        for (int k = 0; k < segCount[seg]; k++) begin
            idx = segFirst[seg] + k;
            row = progTable[idx];
            // Skipped words never retire, so they take no cycle
            if (row.runs) begin
                @(negedge clk);
                checkReg(idx, "a0", row.a0, a0);
                checkReg(idx, "a1", row.a1, a1);
                checkReg(idx, "a7", row.a7, a7);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("TIMEOUT: program did not finish within %0d cycles", cycleLimit);
            errors++;
            $display("Errors: %0d value checks, %0d assertions", errors,
                     dut_i.props_i.failCount);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int failures;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        restart  = 1'b0;
        void'($urandom(SEED));
        buildTable();
        cycleLimit = progTable.size() + RST_CYCLES * NUM_SEGS + MARGIN;
        @(negedge clk);
        for (int seg = 0; seg < NUM_SEGS; seg++) begin
            if (seg > 0) begin
                restart = 1'b1;
                @(negedge clk);
                restart = 1'b0;
            end
            loadSegment(seg);
            runSegment(seg);
        end
        failures = errors + dut_i.props_i.failCount;
        $display("Errors: %0d value checks, %0d assertions", errors, dut_i.props_i.failCount);
        if (failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tb/cpuTop_properties.sv
`timescale 1ns/1ps

module cpuTop_properties import rvPkg::*; (
    input logic       clk,
    input logic       rst,
    input word_t      pc,
    input ctrl_t      ctrl,
    input instrWord_t instr,
    input word_t      rd1,
    input word_t      rd2
);

    int failCount = 0;

    // A reset edge leaves pc at zero
    pcReset: assert property (@(posedge clk) rst |=> (pc == '0))
        else begin
            $error("pc is not zero after a reset edge");
            failCount++;
        end

    pcAligned: assert property (@(posedge clk) !rst |-> (pc[1:0] == 2'b00))
        else begin
            $error("pc is not word aligned");
            failCount++;
        end

    noWritesInReset: assert property (@(posedge clk) rst |-> (!ctrl.regWrite && !ctrl.memWrite))
        else begin
            $error("register or memory write enabled during reset");
            failCount++;
        end

    // x0 on either read port
    x0ReadRs1: assert property (@(posedge clk) disable iff (rst)
        (instr.r.rs1 == 5'd0) |-> (rd1 == '0))
        else begin
            $error("x0 read through rs1 is not zero");
            failCount++;
        end

    x0ReadRs2: assert property (@(posedge clk) disable iff (rst)
        (instr.r.rs2 == 5'd0) |-> (rd2 == '0))
        else begin
            $error("x0 read through rs2 is not zero");
            failCount++;
        end

endmodule

bind cpuTop cpuTop_properties props_i (
    .clk   (clk),
    .rst   (rst),
    .pc    (pc),
    .ctrl  (ctrl),
    .instr (instr),
    .rd1   (rd1),
    .rd2   (rd2)
);

// File: tb/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
    parameter int RST_CYCLES = 16
) (
    input  logic restart,
    output logic clk,
    output logic rst
);

    // Starts high so the first edge is a falling one
    logic clkReg = 1'b1;

    assign clk = clkReg;

    always #5 clkReg = ~clkReg;

    // Reset at start of run, and again on each restart request
    initial begin
        rst = 1'b1;
        forever begin
            repeat (RST_CYCLES) @(posedge clkReg);
            rst <= 1'b0;
            do begin
                @(posedge clkReg);
            end while (!restart);
            rst <= 1'b1;
        end
    end

endmodule

// File: hw/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import rvPkg::*; #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_BYTES = 256
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  progWe,
    input  word_t progAddr,
    input  word_t progData,
    output word_t a0,
    output word_t a1,
    output word_t a7
);

    word_t      pc;
    word_t      pcPlus4;
    instrWord_t instr;
    ctrl_t      ctrl;
    word_t      immExt;
    word_t      rd1;
    word_t      rd2;
    word_t      srcB;
    word_t      aluResult;
    logic       zero;
    word_t      readData;
    word_t      result;

    programCounter pcReg_i (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .zero      (zero),
        .immExt    (immExt),
        .aluResult (aluResult),
        .pc        (pc)
    );

    instrMemory #(
        .IMEM_WORDS (IMEM_WORDS)
    ) imem_i (
        .clk      (clk),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    controlUnit ctrl_i (
        .rst   (rst),
        .instr (instr),
        .ctrl  (ctrl)
    );

    immExtend immExt_i (
        .instr  (instr),
        .immSel (ctrl.immSel),
        .immExt (immExt)
    );

    regFile regFile_i (
        .clk (clk),
        .rst (rst),
        .rs1 (instr.r.rs1),
        .rs2 (instr.r.rs2),
        .rd  (instr.r.rd),
        .we  (ctrl.regWrite),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2),
        .a0  (a0),
        .a1  (a1),
        .a7  (a7)
    );

    // ALU operand B
    assign srcB = ctrl.aluSrcImm ? immExt : rd2;

    alu alu_i (
        .srcA      (rd1),
        .srcB      (srcB),
        .aluOp     (ctrl.aluOp),
        .aluResult (aluResult),
        .zero      (zero)
    );

    dataMemory #(
        .DMEM_BYTES (DMEM_BYTES)
    ) dmem_i (
        .clk      (clk),
        .we       (ctrl.memWrite),
        .memMode  (ctrl.memMode),
        .addr     (aluResult),
        .wd       (rd2),
        .readData (readData)
    );

    // Link value for JAL and JALR
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.resultSrc)
            RES_MEM:     result = readData;
            RES_PCPLUS4: result = pcPlus4;
            default:     result = aluResult;
        endcase
    end

endmodule

// File: hw/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import rvPkg::*; #(
    parameter int DMEM_BYTES = 256
) (
    input  logic     clk,
    input  logic     we,
    input  memMode_e memMode,
    input  word_t    addr,
    input  word_t    wd,
    output word_t    readData
);

    localparam int AW = $clog2(DMEM_BYTES);

    logic [7:0]    mem [DMEM_BYTES];
    logic [AW-1:0] byteIdx;
    logic [AW-1:0] idx0;
    logic [AW-1:0] idx1;
    logic [AW-1:0] idx2;
    logic [AW-1:0] idx3;
    logic [7:0]    byteData;

    assign byteIdx = addr[AW-1:0];

    // Word accesses ignore the low two address bits
    assign idx0 = {addr[AW-1:2], 2'd0};
    assign idx1 = {addr[AW-1:2], 2'd1};
    assign idx2 = {addr[AW-1:2], 2'd2};
    assign idx3 = {addr[AW-1:2], 2'd3};

    always_ff @(posedge clk) begin
        if (we) begin
            if (memMode == MEM_WORD) begin
                mem[idx0] <= wd[7:0];
                mem[idx1] <= wd[15:8];
                mem[idx2] <= wd[23:16];
                mem[idx3] <= wd[31:24];
            end else begin
                mem[byteIdx] <= wd[7:0];
            end
        end
    end

    assign byteData = mem[byteIdx];

    always_comb begin
        case (memMode)
            MEM_BYTE:  readData = {{24{byteData[7]}}, byteData};
            MEM_BYTEU: readData = {24'b0, byteData};
            default:   readData = {mem[idx3], mem[idx2], mem[idx1], mem[idx0]};
        endcase
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input  word_t  srcA,
    input  word_t  srcB,
    input  aluOp_e aluOp,
    output word_t  aluResult,
    output logic   zero
);

    logic [4:0] shamt;

    assign shamt = srcB[4:0];

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = srcA + srcB;
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR:  aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            // signed compare
            ALU_SLT: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            ALU_SLL: aluResult = srcA << shamt;
            ALU_SRL: aluResult = srcA >> shamt;
            // LUI just forwards the upper immediate
            ALU_PASSB: aluResult = srcB;
            default: aluResult = '0;
        endcase
    end

    // Branch compare uses SUB, equal operands give zero
    assign zero = (aluResult == '0);

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps

module regFile import rvPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  logic       we,
    input  word_t      wd,
    output word_t      rd1,
    output word_t      rd2,
    output word_t      a0,
    output word_t      a1,
    output word_t      a7
);

    word_t regs [32];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // ABI taps
    assign a0 = regs[10];
    assign a1 = regs[11];
    assign a7 = regs[17];

endmodule

// File: hw/immExtend.sv
`timescale 1ns/1ps

module immExtend import rvPkg::*; (
    input  instrWord_t instr,
    input  immSel_e    immSel,
    output word_t      immExt
);

    always_comb begin
        case (immSel)
            IMM_I: immExt = {{20{instr.i.imm12[11]}}, instr.i.imm12};
            IMM_S: immExt = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            IMM_B: begin
                immExt = {{20{instr.b.immSign}}, instr.b.imm11,
                          instr.b.imm10to5, instr.b.imm4to1, 1'b0};
            end
            // Upper immediate, low 12 bits zero
            IMM_U: immExt = {instr.u.imm20, 12'b0};
            IMM_J: begin
                immExt = {{12{instr.j.immSign}}, instr.j.imm19to12, instr.j.imm11,
                          instr.j.imm10to1, 1'b0};
            end
            default: immExt = '0;
        endcase
    end

endmodule

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit import rvPkg::*; (
    input  logic       rst,
    input  instrWord_t instr,
    output ctrl_t      ctrl
);

    ctrl_t    dec;
    aluOp_e   funcOp;
    logic     funcOk;
    memMode_e memMode;
    logic     memOk;
    logic     isShift;

    // funct3 decode shared by register and immediate ALU ops
    always_comb begin
        funcOk = 1'b1;
        case (instr.r.funct3)
            3'b000: begin
                if (instr.r.opcode == OP_R && instr.r.funct7[5]) begin
                    funcOp = ALU_SUB;
                end else begin
                    funcOp = ALU_ADD;
                end
            end
            3'b111:  funcOp = ALU_AND;
            3'b110:  funcOp = ALU_OR;
            3'b100:  funcOp = ALU_XOR;
            3'b010:  funcOp = ALU_SLT;
            3'b001:  funcOp = ALU_SLL;
            3'b101:  funcOp = ALU_SRL;
            default: begin
                funcOp = ALU_ADD;
                funcOk = 1'b0;
            end
        endcase
    end

    assign isShift = (instr.r.funct3 == 3'b001) || (instr.r.funct3 == 3'b101);

    // Access width for loads and stores
    always_comb begin
        memOk = 1'b1;
        case (instr.i.funct3)
            3'b010:  memMode = MEM_WORD;
            3'b000:  memMode = MEM_BYTE;
            3'b100:  memMode = MEM_BYTEU;
            default: begin
                memMode = MEM_WORD;
                memOk   = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec = '{aluOp: ALU_ADD, aluSrcImm: 1'b0, resultSrc: RES_ALU, pcSrc: PC_SEQ,
                memMode: memMode, memWrite: 1'b0, regWrite: 1'b0, immSel: IMM_I};
        case (instr.r.opcode)
            OP_R: begin
                dec.aluOp    = funcOp;
                // SRA is not supported
                dec.regWrite = funcOk && !(instr.r.funct3 == 3'b101 && instr.r.funct7[5]);
            end
            OP_IMM: begin
                dec.aluOp     = funcOp;
                dec.aluSrcImm = 1'b1;
                dec.regWrite  = funcOk && !isShift;
            end
            OP_LOAD: begin
                dec.aluSrcImm = 1'b1;
                dec.resultSrc = RES_MEM;
                dec.regWrite  = memOk;
            end
            OP_STORE: begin
                dec.aluSrcImm = 1'b1;
                dec.immSel    = IMM_S;
                dec.memWrite  = memOk && (memMode != MEM_BYTEU);
            end
            OP_BRANCH: begin
                dec.aluOp  = ALU_SUB;
                dec.immSel = IMM_B;
                if (instr.b.funct3 == 3'b000) begin
                    dec.pcSrc = PC_BEQ;
                end else if (instr.b.funct3 == 3'b001) begin
                    dec.pcSrc = PC_BNE;
                end
            end
            OP_JAL: begin
                dec.immSel    = IMM_J;
                dec.pcSrc     = PC_JAL;
                dec.resultSrc = RES_PCPLUS4;
                dec.regWrite  = 1'b1;
            end
            OP_JALR: begin
                dec.aluSrcImm = 1'b1;
                dec.pcSrc     = PC_JALR;
                dec.resultSrc = RES_PCPLUS4;
                dec.regWrite  = 1'b1;
            end
            OP_LUI: begin
                dec.aluOp     = ALU_PASSB;
                dec.aluSrcImm = 1'b1;
                dec.immSel    = IMM_U;
                dec.regWrite  = 1'b1;
            end
            default: ;
        endcase
    end

    // No architectural writes while the core is held in reset
    always_comb begin
        ctrl = dec;
        if (rst) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

// File: hw/instrMemory.sv
`timescale 1ns/1ps

module instrMemory import rvPkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic       clk,
    input  logic       progWe,
    input  word_t      progAddr,
    input  word_t      progData,
    input  word_t      pc,
    output instrWord_t instr
);

    localparam int AW = $clog2(IMEM_WORDS);

    word_t mem [IMEM_WORDS];

    // Empty slots decode as an unknown opcode, so they do nothing
    initial begin
        for (int i = 0; i < IMEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // progAddr is a byte address, same as pc
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr[AW+1:2]] <= progData;
        end
    end

    assign instr = instrWord_t'(mem[pc[AW+1:2]]);

endmodule

// File: hw/programCounter.sv
`timescale 1ns/1ps

module programCounter import rvPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  ctrl_t ctrl,
    input  logic  zero,
    input  word_t immExt,
    input  word_t aluResult,
    output word_t pc
);

    word_t pcPlus4;
    word_t branchTarget;
    word_t jalrTarget;
    word_t pcNext;
    logic  takeBranch;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pc + immExt;
    // JALR target drops bit 0
    assign jalrTarget   = {aluResult[31:1], 1'b0};

    // zero comes from the SUB compare of rs1 and rs2
    assign takeBranch = ((ctrl.pcSrc == PC_BEQ) && zero) ||
                        ((ctrl.pcSrc == PC_BNE) && !zero);

    always_comb begin
        case (ctrl.pcSrc)
            PC_BEQ, PC_BNE: pcNext = takeBranch ? branchTarget : pcPlus4;
            PC_JAL:         pcNext = branchTarget;
            PC_JALR:        pcNext = jalrTarget;
            default:        pcNext = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: hw/rvPkg.sv
package rvPkg;

    typedef logic [31:0] word_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       immSign;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    typedef struct packed {
        logic       immSign;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    // One fetched word, read through whichever format applies
    typedef union packed {
        rType_t      r;
        iType_t      i;
        sType_t      s;
        bType_t      b;
        uType_t      u;
        jType_t      j;
        logic [31:0] raw;
    } instrWord_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASSB
    } aluOp_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSel_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PCPLUS4} resultSrc_e;

    typedef enum logic [2:0] {PC_SEQ, PC_BEQ, PC_BNE, PC_JAL, PC_JALR} pcSrc_e;

    typedef enum logic [1:0] {MEM_WORD, MEM_BYTE, MEM_BYTEU} memMode_e;

    typedef struct packed {
        aluOp_e     aluOp;
        logic       aluSrcImm;
        resultSrc_e resultSrc;
        pcSrc_e     pcSrc;
        memMode_e   memMode;
        logic       memWrite;
        logic       regWrite;
        immSel_e    immSel;
    } ctrl_t;

endpackage
